/* Makefile */
TOP       ?= tb_ex_stage
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f files.f
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/imm_gen.sv
hdl/alu.sv
hdl/exu.sv
hdl/ex_stage_top.sv
sim/ex_stage_sva.sv
sim/ex_checker.sv
sim/tb_ex_stage.sv

/* hdl/alu.sv */
`timescale 1ns/10ps

module alu
    import isa_pkg::*;
#(
    parameter int BW = 32
) (
    input  logic [BW-1:0] a,
    input  logic [BW-1:0] b,
    input  alu_op_e       op,
    output logic [BW-1:0] res
);

    localparam int SHW = $clog2(BW);

    logic [SHW-1:0] shamt;
    logic           lt_signed;
    logic           lt_unsigned;

    // only the low bits of b count as a shift amount.
    assign shamt = b[SHW-1:0];

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add: begin
                res = a + b;
            end
            alu_sub: begin
                res = a - b;
            end
            alu_and: begin
                res = a & b;
            end
            alu_or: begin
                res = a | b;
            end
            alu_xor: begin
                res = a ^ b;
            end
            alu_sll: begin
                res = a << shamt;
            end
            alu_srl: begin
                res = a >> shamt;
            end
            alu_sra: begin
                res = $unsigned($signed(a) >>> shamt);
            end
            alu_slt: begin
                res = {{(BW-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                res = {{(BW-1){1'b0}}, lt_unsigned};
            end
            alu_pass_b: begin
                // used by lui and by CSR reads.
                res = b;
            end
            default: begin
                res = '0;
            end
        endcase
    end

endmodule

/* hdl/ex_stage_top.sv */
`timescale 1ns/10ps

module ex_stage_top
    import pipe_pkg::*;
#(
    parameter int BW = 32
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  id_ex_t  in_bundle,
    output logic    out_valid,
    output ex_mem_t out_bundle
);

    id_ex_t  id_ex_q;
    logic    id_valid_q;
    ex_mem_t ex_mem_d;

    // input register. The bundle only moves on a valid cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid_q <= 1'b0;
            id_ex_q    <= '0;
        end else begin
            id_valid_q <= in_valid;
            if (in_valid) begin
                id_ex_q <= in_bundle;
            end
        end
    end

    exu #(
        .BW (BW)
    ) u_exu (
        .id_ex  (id_ex_q),
        .ex_mem (ex_mem_d)
    );

    // output register. out_bundle holds its last value through bubbles.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            out_bundle <= '0;
        end else begin
            out_valid <= id_valid_q;
            if (id_valid_q) begin
                out_bundle <= ex_mem_d;
            end
        end
    end

endmodule

/* hdl/exu.sv */
`timescale 1ns/10ps

module exu
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int BW = 32
) (
    input  id_ex_t  id_ex,
    output ex_mem_t ex_mem
);

    word_t imm_value;
    word_t op_a;
    word_t op_b;
    word_t alu_res;
    word_t result;

    imm_gen u_imm_gen (
        .imm       (id_ex.imm),
        .imm_kind  (id_ex.imm_kind),
        .imm_value (imm_value)
    );

    // the unused select code falls through to zero.
    always_comb begin
        case (id_ex.src1_sel)
            src1_reg: begin
                op_a = id_ex.rs1_value;
            end
            src1_pc: begin
                op_a = id_ex.pc;
            end
            default: begin
                op_a = '0;
            end
        endcase
    end

    always_comb begin
        case (id_ex.src2_sel)
            src2_imm: begin
                op_b = imm_value;
            end
            src2_rs2: begin
                op_b = id_ex.rs2_value;
            end
            src2_csr: begin
                op_b = id_ex.csr_value;
            end
            default: begin
                op_b = '0;
            end
        endcase
    end

    alu #(
        .BW (BW)
    ) u_alu (
        .a   (op_a),
        .b   (op_b),
        .op  (id_ex.alu_op),
        .res (alu_res)
    );

    // bne and bge reuse the eq and lt compares by flipping bit 0.
    assign result = {alu_res[31:1], alu_res[0] ^ id_ex.inv_flag};

    assign ex_mem.jump_flag = id_ex.jump_flag;
    assign ex_mem.funct3    = id_ex.funct3;
    assign ex_mem.rs2_value = id_ex.rs2_value;
    assign ex_mem.rd        = id_ex.rd;
    assign ex_mem.csr_value = id_ex.csr_value;
    assign ex_mem.csr_wen   = id_ex.csr_wen;
    assign ex_mem.reg_wen   = id_ex.reg_wen;
    assign ex_mem.mem_wen   = id_ex.mem_wen;
    assign ex_mem.mem_ren   = id_ex.mem_ren;
    assign ex_mem.pc        = id_ex.pc;
    assign ex_mem.result    = result;

endmodule

/* hdl/imm_gen.sv */
`timescale 1ns/10ps

module imm_gen
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  word_t     imm,
    input  imm_kind_e imm_kind,
    output word_t     imm_value
);

    word_t imm_i12_sx;
    word_t imm_j20_sx;

    // sign extension from the top bit of each signed field.
    assign imm_i12_sx = {{20{imm[11]}}, imm[11:0]};
    assign imm_j20_sx = {{12{imm[19]}}, imm[19:0]};

    // bits above each field are ignored.
    always_comb begin
        case (imm_kind)
            imm_i12: begin
                imm_value = imm_i12_sx;
            end
            imm_u20: begin
                imm_value = {imm[19:0], 12'd0};
            end
            imm_j20: begin
                // jump offsets are stored in half-word units.
                imm_value = {imm_j20_sx[30:0], 1'b0};
            end
            imm_u5: begin
                imm_value = {27'd0, imm[4:0]};
            end
            default: begin
                imm_value = '0;
            end
        endcase
    end

endmodule

/* hdl/isa_pkg.sv */
package isa_pkg;

    // immediate layouts, one per instruction format family.
    typedef enum logic [1:0] {
        imm_i12 = 2'd0,
        imm_u20 = 2'd1,
        imm_j20 = 2'd2,
        imm_u5  = 2'd3
    } imm_kind_e;

    // codes 11 to 15 are left free and give a zero result.
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_slt    = 4'd8,
        alu_sltu   = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

    // the fourth code is unused and selects zero.
    typedef enum logic [1:0] {
        src1_reg  = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2
    } src1_sel_e;

    typedef enum logic [1:0] {
        src2_imm  = 2'd0,
        src2_rs2  = 2'd1,
        src2_csr  = 2'd2,
        src2_zero = 2'd3
    } src2_sel_e;

endpackage

/* hdl/pipe_pkg.sv */
package pipe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [3:0]  csr_wen_t;

    // bundle handed over by the decode stage.
    typedef struct packed {
        word_t               pc;
        csr_wen_t            csr_wen;
        logic                reg_wen;
        logic                mem_wen;
        logic                mem_ren;
        reg_addr_t           rd;
        funct3_t             funct3;
        word_t               imm;
        isa_pkg::imm_kind_e  imm_kind;
        isa_pkg::alu_op_e    alu_op;
        logic                inv_flag;
        logic                jump_flag;
        isa_pkg::src1_sel_e  src1_sel;
        isa_pkg::src2_sel_e  src2_sel;
        word_t               rs1_value;
        word_t               rs2_value;
        word_t               csr_value;
    } id_ex_t;

    // bundle handed on to the memory stage.
    // result doubles as the jump target when jump_flag is set.
    typedef struct packed {
        logic                jump_flag;
        funct3_t             funct3;
        word_t               rs2_value;
        reg_addr_t           rd;
        word_t               csr_value;
        csr_wen_t            csr_wen;
        logic                reg_wen;
        logic                mem_wen;
        logic                mem_ren;
        word_t               pc;
        word_t               result;
    } ex_mem_t;

endpackage

/* sim/ex_checker.sv */
`timescale 1ns/10ps

module ex_checker
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  id_ex_t  in_bundle,
    input  logic    out_valid,
    input  ex_mem_t out_bundle,
    input  logic    test_end,
    output int      err_count
);

    ex_mem_t exp_q[$];
    int      errors = 0;

    assign err_count = errors;

    function automatic word_t expand_imm(word_t imm, imm_kind_e kind);
        word_t v;
        case (kind)
            imm_i12: begin
                v = imm & 32'h0000_0fff;
                if (v[11]) begin
                    v = v | 32'hffff_f000;
                end
            end
            imm_u20: begin
                v = (imm & 32'h000f_ffff) << 12;
            end
            imm_j20: begin
                v = imm & 32'h000f_ffff;
                if (v[19]) begin
                    v = v | 32'hfff0_0000;
                end
                v = v << 1;
            end
            default: begin
                v = imm & 32'h0000_001f;
            end
        endcase
        return v;
    endfunction

    function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
        int unsigned sh;
        sh = b & 32'h1f;
        case (op)
            alu_add:    return a + b;
            alu_sub:    return a - b;
            alu_and:    return a & b;
            alu_or:     return a | b;
            alu_xor:    return a ^ b;
            alu_sll:    return a << sh;
            alu_srl:    return a >> sh;
            alu_sra:    return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            // flipping the sign bits turns a signed compare into an unsigned one.
            alu_slt:    return {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            alu_sltu:   return {31'd0, a < b};
            alu_pass_b: return b;
            default:    return '0;
        endcase
    endfunction

    function automatic ex_mem_t expected_out(id_ex_t b);
        ex_mem_t e;
        word_t   a_op;
        word_t   b_op;
        case (b.src1_sel)
            src1_reg: a_op = b.rs1_value;
            src1_pc:  a_op = b.pc;
            default:  a_op = '0;
        endcase
        case (b.src2_sel)
            src2_imm: b_op = expand_imm(b.imm, b.imm_kind);
            src2_rs2: b_op = b.rs2_value;
            src2_csr: b_op = b.csr_value;
            default:  b_op = '0;
        endcase
        e.result    = alu_model(b.alu_op, a_op, b_op) ^ {31'd0, b.inv_flag};
        e.jump_flag = b.jump_flag;
        e.funct3    = b.funct3;
        e.rs2_value = b.rs2_value;
        e.rd        = b.rd;
        e.csr_value = b.csr_value;
        e.csr_wen   = b.csr_wen;
        e.reg_wen   = b.reg_wen;
        e.mem_wen   = b.mem_wen;
        e.mem_ren   = b.mem_ren;
        e.pc        = b.pc;
        return e;
    endfunction

    task automatic check_field(string name, word_t got, word_t want);
        if (got !== want) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        ex_mem_t want;
        if (!rst_n) begin
            // bundles in flight are lost in the DUT as well.
            exp_q.delete();
            if (out_valid) begin
                $display("out_valid was high at %0t while reset was asserted", $time);
                errors++;
            end
        end else begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("out_valid was high at %0t with no bundle expected", $time);
                    errors++;
                end else begin
                    want = exp_q.pop_front();
                    check_field("jump_flag", 32'(out_bundle.jump_flag), 32'(want.jump_flag));
                    check_field("funct3", 32'(out_bundle.funct3), 32'(want.funct3));
                    check_field("rs2_value", out_bundle.rs2_value, want.rs2_value);
                    check_field("rd", 32'(out_bundle.rd), 32'(want.rd));
                    check_field("csr_value", out_bundle.csr_value, want.csr_value);
                    check_field("csr_wen", 32'(out_bundle.csr_wen), 32'(want.csr_wen));
                    check_field("reg_wen", 32'(out_bundle.reg_wen), 32'(want.reg_wen));
                    check_field("mem_wen", 32'(out_bundle.mem_wen), 32'(want.mem_wen));
                    check_field("mem_ren", 32'(out_bundle.mem_ren), 32'(want.mem_ren));
                    check_field("pc", out_bundle.pc, want.pc);
                    check_field("result", out_bundle.result, want.result);
                end
            end
            if (in_valid) begin
                exp_q.push_back(expected_out(in_bundle));
            end
            if (test_end && exp_q.size() != 0) begin
                $display("%0d expected bundles never came out of the stage", exp_q.size());
                errors++;
                exp_q.delete();
            end
        end
    end

endmodule

/* sim/ex_stage_sva.sv */
`timescale 1ns/10ps

module ex_stage_sva
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    in_valid,
    input logic    out_valid,
    input ex_mem_t out_bundle
);

    property reset_quiet;
        @(posedge clk) !rst_n |-> !out_valid;
    endproperty

    // two register stages sit between in_valid and out_valid.
    property valid_delay;
        @(posedge clk) disable iff (!rst_n) out_valid == $past(in_valid, 2);
    endproperty

    property bundle_hold;
        @(posedge clk) disable iff (!rst_n) !out_valid |-> $stable(out_bundle);
    endproperty

    a_reset_quiet: assert property (reset_quiet)
        else $error("out_valid high during reset");
    a_valid_delay: assert property (valid_delay)
        else $error("out_valid does not follow in_valid by two cycles");
    a_bundle_hold: assert property (bundle_hold)
        else $error("out_bundle changed while out_valid was low");

endmodule

bind ex_stage_top ex_stage_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .out_bundle (out_bundle)
);

/* sim/tb_ex_stage.sv */
`timescale 1ns/10ps

module tb_ex_stage
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int LEN_SHORT     = 200;
    localparam int LEN_LONG      = 400;
    localparam int TEST_OVERHEAD = 6;
    localparam int CYCLE_LIMIT   = 16 + 5 * LEN_SHORT + LEN_LONG + 3
                                   + 6 * TEST_OVERHEAD + 100;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    id_ex_t      in_bundle;
    logic        out_valid;
    ex_mem_t     out_bundle;
    logic        test_end;
    int          err_count;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;
    logic [31:0] rng_state = 32'd23;

    ex_stage_top #(
        .BW (32)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_bundle  (in_bundle),
        .out_valid  (out_valid),
        .out_bundle (out_bundle)
    );

    ex_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_bundle  (in_bundle),
        .out_valid  (out_valid),
        .out_bundle (out_bundle),
        .test_end   (test_end),
        .err_count  (err_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("the run timed out after %0d cycles", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // values around the signed and unsigned wrap points.
    function automatic word_t boundary_value(logic [1:0] sel);
        case (sel)
            2'd0:    return 32'h8000_0000;
            2'd1:    return 32'h7fff_ffff;
            2'd2:    return 32'h0000_0000;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic id_ex_t make_bundle(int id);
        id_ex_t      b;
        logic [31:0] r;
        r = next_rand();
        b.pc        = next_rand();
        b.imm       = next_rand();
        b.rs1_value = next_rand();
        b.rs2_value = next_rand();
        b.csr_value = next_rand();
        b.csr_wen   = r[3:0];
        b.reg_wen   = r[4];
        b.mem_wen   = r[5];
        b.mem_ren   = r[6];
        b.rd        = r[11:7];
        b.funct3    = r[14:12];
        b.imm_kind  = imm_kind_e'(r[16:15]);
        b.alu_op    = alu_op_e'(r[20:17]);
        b.inv_flag  = r[21];
        b.jump_flag = r[22];
        b.src1_sel  = src1_sel_e'(r[24:23]);
        b.src2_sel  = src2_sel_e'(r[26:25]);
        case (id)
            1: begin
                b.src1_sel = src1_reg;
                b.src2_sel = src2_rs2;
                b.inv_flag = 1'b0;
                if (r[27]) begin
                    b.rs1_value = boundary_value(r[29:28]);
                    b.rs2_value = boundary_value(r[31:30]);
                end
            end
            2: begin
                b.src1_sel = src1_zero;
                b.src2_sel = src2_imm;
                b.alu_op   = alu_add;
                b.inv_flag = 1'b0;
            end
            3: begin
                b.inv_flag = 1'b0;
                case (r[28:27])
                    2'd0: begin
                        b.src1_sel  = src1_pc;
                        b.src2_sel  = src2_imm;
                        b.imm_kind  = imm_j20;
                        b.alu_op    = alu_add;
                        b.jump_flag = 1'b1;
                    end
                    2'd1: begin
                        b.src1_sel = src1_pc;
                        b.src2_sel = src2_imm;
                        b.imm_kind = imm_u20;
                        b.alu_op   = alu_add;
                    end
                    2'd2: begin
                        b.src2_sel = src2_csr;
                        b.alu_op   = alu_pass_b;
                    end
                    default: begin
                        b.src1_sel = r[29] ? src1_zero : src1_sel_e'(2'd3);
                        b.src2_sel = src2_zero;
                    end
                endcase
            end
            4: begin
                b.src1_sel = src1_reg;
                b.src2_sel = src2_rs2;
                b.alu_op   = (r[28:27] == 2'd0) ? alu_slt
                           : (r[28:27] == 2'd1) ? alu_sltu : alu_sub;
                if (r[29]) begin
                    b.rs2_value = b.rs1_value;
                end
            end
            default: begin
                // tests 5 and 6 keep every field random.
            end
        endcase
        return b;
    endfunction

    task automatic run_test(input int id, input string name, input int n);
        int          errs_before;
        logic [31:0] r;
        errs_before = err_count;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            if (id == 6 && i == n / 2) begin
                rst_n    = 1'b0;
                in_valid = 1'b0;
                repeat (3) @(posedge clk);
                #1;
                rst_n = 1'b1;
            end
            r         = next_rand();
            in_bundle = make_bundle(id);
            in_valid  = (id == 5) ? r[0] : (r[1:0] != 2'b00);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        // let the last bundles drain before the queue is checked.
        repeat (3) @(posedge clk);
        #1;
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
        if (err_count == errs_before) begin
            pass_count++;
            $display("test %0d (%s): passed", id, name);
        end else begin
            fail_count++;
            $display("test %0d (%s): failed with %0d errors", id, name,
                     err_count - errs_before);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_bundle = '0;
        test_end  = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        run_test(1, "register ALU operations", LEN_SHORT);
        run_test(2, "immediate formats", LEN_SHORT);
        run_test(3, "other operand sources", LEN_SHORT);
        run_test(4, "compare inversion", LEN_SHORT);
        run_test(5, "pass-through and timing", LEN_LONG);
        run_test(6, "reset in the middle of a run", LEN_SHORT);
        $display("%0d tests passed, %0d tests failed, %0d errors in total",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
